/* src/rvd_pkg.sv */
/*
  Shared definitions for the RV32IM decode stage.
  Opcodes follow the RV32 base encoding. Compressed, A, B and CSR are not decoded.
  Register map is word indexed on a 2-bit Wishbone address.
  rf_re bit 0 flags a read of rs1 and bit 1 a read of rs2.
*/
package rvd_pkg;

  //////////////////////////////////////////////////
  // Major opcodes and register map
  //////////////////////////////////////////////////
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_FENCE  = 7'b0001111;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001; // Selects RV32M under OP

  localparam logic [1:0] REG_CTRL     = 2'd0; // Bit 0 is m_en
  localparam logic [1:0] REG_ILL_CNT  = 2'd1; // Illegal count, any write clears
  localparam logic [1:0] REG_ILL_INSN = 2'd2; // Last illegal word, read only

  localparam logic CTRL_RESET = 1'b1;         // M extension on out of reset

  //////////////////////////////////////////////////
  // Operation encodings
  //////////////////////////////////////////////////
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SRL, ALU_SRA,
    ALU_OR,  ALU_AND, ALU_EQ,  ALU_NE,  ALU_LT,   ALU_GE,  ALU_LTU, ALU_GEU
  } alu_op_e;

  typedef enum logic [1:0] {MUL_MUL, MUL_MULH, MUL_MULHSU, MUL_MULHU} mul_op_e; // funct3[1:0]
  typedef enum logic [1:0] {DIV_DIV, DIV_DIVU, DIV_REM, DIV_REMU} div_op_e;     // funct3[1:0]

  typedef enum logic [2:0] {IMM_NONE, IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_sel_e;

  //////////////////////////////////////////////////
  // Instruction word, one view per format
  //////////////////////////////////////////////////
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } instr_r_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } instr_i_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    logic [6:0] opcode;
  } instr_s_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } instr_b_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } instr_u_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } instr_j_t;

  typedef union packed {
    instr_r_t r;
    instr_i_t i;
    instr_s_t s;
    instr_b_t b;
    instr_u_t u;
    instr_j_t j;
  } instr_u;

  //////////////////////////////////////////////////
  // Decoder control and pipe structs
  //////////////////////////////////////////////////
  typedef struct packed {
    logic       alu_en;
    alu_op_e    alu_op;
    logic       op_a_pc;   // Operand a is PC, else rs1 (zero if rf_re[0] clear)
    logic       op_b_imm;  // Operand b is the immediate
    logic       bch;
    logic       jmp;
    logic       mul_en;
    mul_op_e    mul_op;
    logic       div_en;
    div_op_e    div_op;
    logic       lsu_en;
    logic       lsu_we;
    logic [1:0] lsu_size;  // Byte, half, word
    logic       lsu_sext;
    logic       rf_we;
    logic [1:0] rf_re;     // {rs2, rs1}
    imm_sel_e   imm_sel;
    logic       sys_en;
    logic       ecall;
    logic       ebreak;
    logic       mret;
    logic       wfi;
    logic       fencei;
    logic       illegal;
  } decoder_ctrl_t;

  localparam decoder_ctrl_t DECODER_CTRL_ILLEGAL = '{
    alu_op:  ALU_ADD,
    mul_op:  MUL_MUL,
    div_op:  DIV_DIV,
    imm_sel: IMM_NONE,
    illegal: 1'b1,
    default: '0
  };

  typedef struct packed {
    decoder_ctrl_t ctrl;
    logic [4:0]    rs1;
    logic [4:0]    rs2;
    logic [4:0]    rd;
    logic [31:0]   imm;   // Sign extended
    logic [31:0]   instr;
  } id_ex_pipe_t;

  // Wishbone classic, word addressed
  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [1:0]  adr;
    logic [31:0] dat;
    logic [3:0]  sel;
  } wb_req_t;

  typedef struct packed {
    logic        ack;
    logic [31:0] dat;
  } wb_rsp_t;

endpackage

/* src/rvd_i_decoder.sv */
/*
  RV32I sub-decoder, purely combinational.
  CSR accesses and unknown encodings come out as DECODER_CTRL_ILLEGAL.
  OP with funct7 of the M extension is illegal here and left to the M decoder.
  FENCE is a no-op, FENCE.I raises fencei with sys_en.
*/
module rvd_i_decoder import rvd_pkg::*; (
  input  instr_u        instr_i,
  output decoder_ctrl_t ctrl_o
);

  logic          illegal;
  logic          alt;        // funct7 = 0100000 (SUB / SRA)
  logic [2:0]    f3;
  alu_op_e       arith_op;   // ALU op from funct3 for OP / OP_IMM
  decoder_ctrl_t ctrl;

  assign f3  = instr_i.r.funct3;
  assign alt = (instr_i.r.funct7 == 7'b0100000);

  always_comb begin
    unique case (f3)
      3'b000:  arith_op = ALU_ADD;
      3'b001:  arith_op = ALU_SLL;
      3'b010:  arith_op = ALU_SLT;
      3'b011:  arith_op = ALU_SLTU;
      3'b100:  arith_op = ALU_XOR;
      3'b101:  arith_op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  arith_op = ALU_OR;
      default: arith_op = ALU_AND;
    endcase
  end

  always_comb begin
    ctrl         = DECODER_CTRL_ILLEGAL;
    ctrl.illegal = 1'b0;                 // Start from a clean no-op
    illegal      = 1'b0;

    unique case (instr_i.r.opcode)
      OPC_LUI: begin
        ctrl.alu_en   = 1'b1;
        ctrl.op_b_imm = 1'b1;
        ctrl.rf_we    = 1'b1;
        ctrl.imm_sel  = IMM_U;
      end
      OPC_AUIPC: begin
        ctrl.alu_en  = 1'b1;
        ctrl.op_a_pc = 1'b1;
        ctrl.op_b_imm = 1'b1;
        ctrl.rf_we   = 1'b1;
        ctrl.imm_sel = IMM_U;
      end
      OPC_JAL: begin                     // ALU builds the link address
        ctrl.alu_en  = 1'b1;
        ctrl.jmp     = 1'b1;
        ctrl.op_a_pc = 1'b1;
        ctrl.rf_we   = 1'b1;
        ctrl.imm_sel = IMM_J;
      end
      OPC_JALR: begin
        illegal      = (f3 != 3'b000);
        ctrl.alu_en  = 1'b1;
        ctrl.jmp     = 1'b1;
        ctrl.op_a_pc = 1'b1;
        ctrl.rf_we   = 1'b1;
        ctrl.rf_re   = 2'b01;            // Target base from rs1
        ctrl.imm_sel = IMM_I;
      end
      OPC_BRANCH: begin
        ctrl.alu_en  = 1'b1;
        ctrl.bch     = 1'b1;
        ctrl.rf_re   = 2'b11;
        ctrl.imm_sel = IMM_B;
        unique case (f3)
          3'b000:  ctrl.alu_op = ALU_EQ;
          3'b001:  ctrl.alu_op = ALU_NE;
          3'b100:  ctrl.alu_op = ALU_LT;
          3'b101:  ctrl.alu_op = ALU_GE;
          3'b110:  ctrl.alu_op = ALU_LTU;
          3'b111:  ctrl.alu_op = ALU_GEU;
          default: illegal = 1'b1;       // 010, 011 reserved
        endcase
      end
      OPC_LOAD: begin
        illegal       = (f3[1:0] == 2'b11) || (f3 == 3'b110);
        ctrl.lsu_en   = 1'b1;
        ctrl.lsu_size = f3[1:0];
        ctrl.lsu_sext = ~f3[2];          // LBU / LHU zero extend
        ctrl.rf_we    = 1'b1;
        ctrl.rf_re    = 2'b01;
        ctrl.imm_sel  = IMM_I;
      end
      OPC_STORE: begin
        illegal       = f3[2] || (f3[1:0] == 2'b11);
        ctrl.lsu_en   = 1'b1;
        ctrl.lsu_we   = 1'b1;
        ctrl.lsu_size = f3[1:0];
        ctrl.rf_re    = 2'b11;           // Address base and store data
        ctrl.imm_sel  = IMM_S;
      end
      OPC_OP_IMM: begin
        // Shift amounts need a clean upper field
        if (f3 == 3'b001) illegal = (instr_i.r.funct7 != 7'b0);
        if (f3 == 3'b101) illegal = (instr_i.r.funct7 != 7'b0) && !alt;
        ctrl.alu_en   = 1'b1;
        ctrl.alu_op   = arith_op;
        ctrl.op_b_imm = 1'b1;
        ctrl.rf_we    = 1'b1;
        ctrl.rf_re    = 2'b01;
        ctrl.imm_sel  = IMM_I;
      end
      OPC_OP: begin
        // Only ADD and SRL have an alternate form; MULDIV funct7 lands here too
        illegal     = (instr_i.r.funct7 != 7'b0) && !(alt && (f3 == 3'b000 || f3 == 3'b101));
        ctrl.alu_en = 1'b1;
        ctrl.alu_op = (alt && f3 == 3'b000) ? ALU_SUB : arith_op;
        ctrl.rf_we  = 1'b1;
        ctrl.rf_re  = 2'b11;
      end
      OPC_FENCE: begin
        illegal     = (f3[2:1] != 2'b00);
        ctrl.fencei = (f3 == 3'b001);
        ctrl.sys_en = (f3 == 3'b001);    // Plain FENCE stays a no-op
      end
      OPC_SYSTEM: begin
        ctrl.sys_en = 1'b1;
        if (f3 != 3'b000 || instr_i.r.rs1 != 5'd0 || instr_i.r.rd != 5'd0) begin
          illegal = 1'b1;                // CSR ops included
        end else begin
          unique case (instr_i.i.imm_11_0)
            12'h000: ctrl.ecall  = 1'b1;
            12'h001: ctrl.ebreak = 1'b1;
            12'h302: ctrl.mret   = 1'b1;
            12'h105: ctrl.wfi    = 1'b1;
            default: illegal = 1'b1;
          endcase
        end
      end
      default: illegal = 1'b1;
    endcase

    ctrl_o = illegal ? DECODER_CTRL_ILLEGAL : ctrl;
  end

endmodule

/* src/rvd_m_decoder.sv */
/*
  RV32M sub-decoder, purely combinational.
  Only OP with funct7 0000001 matches, anything else is illegal.
*/
module rvd_m_decoder import rvd_pkg::*; (
  input  instr_u        instr_i,
  output decoder_ctrl_t ctrl_o
);

  always_comb begin
    ctrl_o = DECODER_CTRL_ILLEGAL;

    if (instr_i.r.opcode == OPC_OP && instr_i.r.funct7 == FUNCT7_MULDIV) begin
      ctrl_o.illegal = 1'b0;
      ctrl_o.rf_we   = 1'b1;
      ctrl_o.rf_re   = 2'b11;                               // Both operands from the RF
      if (!instr_i.r.funct3[2]) begin
        ctrl_o.mul_en = 1'b1;
        ctrl_o.mul_op = mul_op_e'(instr_i.r.funct3[1:0]);  // MUL, MULH, MULHSU, MULHU
      end else begin
        ctrl_o.div_en = 1'b1;
        ctrl_o.div_op = div_op_e'(instr_i.r.funct3[1:0]);  // DIV, DIVU, REM, REMU
      end
    end
  end

endmodule

/* src/rvd_decoder.sv */
/*
  Decoder wrapper, combinational with zero latency.
  M results only win while m_en_i is set.
  kill_i clears the enables, rf_we and illegal; op fields pass unchanged.
*/
module rvd_decoder import rvd_pkg::*; (
  input  instr_u        instr_i,
  input  logic          m_en_i,   // From the config block
  input  logic          kill_i,   // Instruction killed by the controller
  output decoder_ctrl_t ctrl_o
);

  decoder_ctrl_t i_ctrl;
  decoder_ctrl_t m_ctrl;
  decoder_ctrl_t mux_ctrl;

  // Base ISA
  rvd_i_decoder i_decoder_i (
    .instr_i ( instr_i ),
    .ctrl_o  ( i_ctrl  )
  );

  // Multiply / divide
  rvd_m_decoder m_decoder_i (
    .instr_i ( instr_i ),
    .ctrl_o  ( m_ctrl  )
  );

  // Priority merge of the sub-decoder results
  always_comb begin
    if (m_en_i && !m_ctrl.illegal) begin
      mux_ctrl = m_ctrl;                 // M match
    end else if (!i_ctrl.illegal) begin
      mux_ctrl = i_ctrl;                 // Base match
    end else begin
      mux_ctrl = DECODER_CTRL_ILLEGAL;   // No match anywhere
    end
  end

  // Kill suppression
  always_comb begin
    ctrl_o = mux_ctrl;
    if (kill_i) begin
      ctrl_o.alu_en  = 1'b0;
      ctrl_o.mul_en  = 1'b0;
      ctrl_o.div_en  = 1'b0;
      ctrl_o.lsu_en  = 1'b0;
      ctrl_o.sys_en  = 1'b0;
      ctrl_o.rf_we   = 1'b0;
      ctrl_o.illegal = 1'b0;             // Killed words are never counted
    end
  end

endmodule

/* src/rvd_cfg_regs.sv */
/*
  Wishbone classic register block of the decode stage.
  Ack comes one cycle after cyc and stb, lasts one cycle, then the slave waits
  for stb or cyc to drop. Writes land on the ack edge.
  Illegal counter wraps at 2^32; a clear write beats a same-edge increment.
*/
module rvd_cfg_regs import rvd_pkg::*; (
  input  logic        clk,
  input  logic        rst_i,
  input  wb_req_t     wb_req_i,
  output wb_rsp_t     wb_rsp_o,
  input  logic        ill_event_i,   // One pulse per accepted illegal word
  input  logic [31:0] ill_insn_i,
  output logic        m_en_o
);

  logic        req;          // New request to serve this cycle
  logic        wr;
  logic        served_q;     // Current strobe already answered
  logic        ack_q;
  logic [31:0] rdata_q;
  logic        m_en_q;
  logic [31:0] ill_cnt_q;
  logic [31:0] ill_insn_q;

  assign req = wb_req_i.cyc & wb_req_i.stb & ~served_q;
  assign wr  = req & wb_req_i.we;

  //////////////////////////////////////////////////
  // Bus handshake
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst_i) begin
      served_q <= 1'b0;
      ack_q    <= 1'b0;
    end else begin
      ack_q    <= req;                                    // Single-cycle ack
      served_q <= (wb_req_i.cyc & wb_req_i.stb) & (served_q | req);
    end
  end

  // Read data, sampled with the request
  always_ff @(posedge clk) begin
    if (req) begin
      unique case (wb_req_i.adr)
        REG_CTRL:     rdata_q <= {31'b0, m_en_q};
        REG_ILL_CNT:  rdata_q <= ill_cnt_q;
        REG_ILL_INSN: rdata_q <= ill_insn_q;
        default:      rdata_q <= '0;                      // Unmapped word
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Registers
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst_i) begin
      m_en_q     <= CTRL_RESET;
      ill_cnt_q  <= '0;
      ill_insn_q <= '0;
    end else begin
      if (wr && wb_req_i.adr == REG_CTRL && wb_req_i.sel[0]) m_en_q <= wb_req_i.dat[0];

      if (wr && wb_req_i.adr == REG_ILL_CNT) begin
        ill_cnt_q <= '0;                                  // Any write clears
      end else if (ill_event_i) begin
        ill_cnt_q <= ill_cnt_q + 32'd1;
      end

      if (ill_event_i) ill_insn_q <= ill_insn_i;          // Last offender
    end
  end

  assign wb_rsp_o.ack = ack_q;
  assign wb_rsp_o.dat = rdata_q;
  assign m_en_o       = m_en_q;

endmodule

/* src/rvd_id_stage.sv */
/*
  RV32IM decode stage, top level.
  valid/ready on both sides; one cycle from accept to ex_valid_o, full throughput.
  Source holds instr_i stable while it waits for ready.
  Killed words still produce a beat with their enables cleared.
*/
module rvd_id_stage import rvd_pkg::*; (
  input  logic        clk,
  input  logic        rst_i,
  input  logic        instr_valid_i,
  input  logic [31:0] instr_i,
  output logic        instr_ready_o,
  input  logic        kill_i,
  output logic        ex_valid_o,
  output id_ex_pipe_t ex_pipe_o,
  input  logic        ex_ready_i,
  input  wb_req_t     wb_req_i,
  output wb_rsp_t     wb_rsp_o
);

  instr_u        instr;
  decoder_ctrl_t ctrl;
  logic          m_en;
  logic          accept;
  logic          ill_event;
  logic [31:0]   imm;
  id_ex_pipe_t   pipe_d;
  id_ex_pipe_t   pipe_q;
  logic          valid_q;

  assign instr         = instr_i;
  assign instr_ready_o = ~valid_q | ex_ready_i;    // Stage empty or draining
  assign accept        = instr_valid_i & instr_ready_o;
  assign ill_event     = accept & ctrl.illegal;    // Already zero when killed

  rvd_decoder decoder_i (
    .instr_i ( instr  ),
    .m_en_i  ( m_en   ),
    .kill_i  ( kill_i ),
    .ctrl_o  ( ctrl   )
  );

  rvd_cfg_regs cfg_regs_i (
    .clk         ( clk       ),
    .rst_i       ( rst_i     ),
    .wb_req_i    ( wb_req_i  ),
    .wb_rsp_o    ( wb_rsp_o  ),
    .ill_event_i ( ill_event ),
    .ill_insn_i  ( instr_i   ),
    .m_en_o      ( m_en      )
  );

  //////////////////////////////////////////////////
  // Immediate assembly, sign extended
  //////////////////////////////////////////////////
  always_comb begin
    unique case (ctrl.imm_sel)
      IMM_I: imm = {{20{instr.i.imm_11_0[11]}}, instr.i.imm_11_0};
      IMM_S: imm = {{20{instr.s.imm_11_5[6]}}, instr.s.imm_11_5, instr.s.imm_4_0};
      IMM_B: imm = {{20{instr.b.imm_12}}, instr.b.imm_11, instr.b.imm_10_5,
                    instr.b.imm_4_1, 1'b0};
      IMM_U: imm = {instr.u.imm_31_12, 12'b0};
      IMM_J: imm = {{12{instr.j.imm_20}}, instr.j.imm_19_12, instr.j.imm_11,
                    instr.j.imm_10_1, 1'b0};
      default: imm = '0;                           // No immediate
    endcase
  end

  always_comb begin
    pipe_d.ctrl  = ctrl;
    pipe_d.rs1   = instr.r.rs1;
    pipe_d.rs2   = instr.r.rs2;
    pipe_d.rd    = instr.r.rd;
    pipe_d.imm   = imm;
    pipe_d.instr = instr_i;
  end

  //////////////////////////////////////////////////
  // ID/EX register
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst_i) begin
      valid_q <= 1'b0;
    end else if (instr_ready_o) begin
      valid_q <= instr_valid_i;                    // Refill or go empty
    end
  end

  always_ff @(posedge clk) begin
    if (accept) pipe_q <= pipe_d;                  // Holds under back-pressure
  end

  assign ex_valid_o = valid_q;
  assign ex_pipe_o  = pipe_q;

endmodule

/* bench/tb_rvd.sv */
/*
  Testbench for the RV32IM decode stage.
  Expected pipe beats come from a reference decode written from the ISA rules.
  Source side always holds its word until accepted; back-pressure is random.
  m_en and the illegal counter are only touched while the stage is empty.
*/
module tb_rvd import rvd_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int TIMEOUT = 100;            // Cycles per wait
  localparam int N_RAND  = 200;
  localparam logic [76:0] OPCODES = {OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_BRANCH,
                                     OPC_LOAD, OPC_STORE, OPC_OP_IMM, OPC_OP, OPC_FENCE,
                                     OPC_SYSTEM};

  logic        clk;
  logic        rst_i;
  logic        instr_valid_i;
  logic [31:0] instr_i;
  logic        instr_ready_o;
  logic        kill_i;
  logic        ex_valid_o;
  id_ex_pipe_t ex_pipe_o;
  logic        ex_ready_i;
  wb_req_t     wb_req_i;
  wb_rsp_t     wb_rsp_o;

  integer      seed = 32'h8d74476d;
  int          mismatches = 0;
  int          failures = 0;
  int          accepted = 0;
  int          beats = 0;
  logic        bp_en = 1'b0;             // Random ex_ready_i when set
  logic        m_en_exp = CTRL_RESET;
  int          ill_cnt_exp = 0;
  logic [31:0] last_ill_exp = '0;
  logic        hold_q = 1'b0;
  id_ex_pipe_t pipe_prev;
  id_ex_pipe_t sb [$];                   // Expected beats, oldest first
  logic [31:0] rand_words [N_RAND];
  logic        rand_kill [N_RAND];

  // Directed RV32I words, legal and illegal mixed
  logic [31:0] base_words [$] = '{
    32'h123452b7, 32'hfffff097, 32'hfe1ff0ef, 32'h00008067, 32'h00009067, // U, J, JALR
    32'h00b50463, 32'hfeb54ee3, 32'h00b52463,                             // Branches
    32'hffc12503, 32'h00014503, 32'h00013503, 32'h00016503,               // Loads
    32'h00a12223, 32'h00a10023, 32'h00a14023,                             // Stores
    32'hfff00513, 32'h00351513, 32'h40351513, 32'h40355513, 32'h00355513,
    32'h04355513, 32'h40050513,                                           // OP-IMM
    32'h00b50533, 32'h40b50533, 32'h40b55533, 32'h00b57533, 32'h40b54533, // OP
    32'h0ff0000f, 32'h0000100f, 32'h0000200f,                             // FENCE
    32'h00000073, 32'h00100073, 32'h30200073, 32'h10500073,               // SYSTEM
    32'h34011073, 32'h000000f3, 32'h00200073, 32'h0000007f, 32'h00000000
  };

  rvd_id_stage DUT (
    .clk           ( clk           ),
    .rst_i         ( rst_i         ),
    .instr_valid_i ( instr_valid_i ),
    .instr_i       ( instr_i       ),
    .instr_ready_o ( instr_ready_o ),
    .kill_i        ( kill_i        ),
    .ex_valid_o    ( ex_valid_o    ),
    .ex_pipe_o     ( ex_pipe_o     ),
    .ex_ready_i    ( ex_ready_i    ),
    .wb_req_i      ( wb_req_i      ),
    .wb_rsp_o      ( wb_rsp_o      )
  );

  always #5 clk = ~clk;

  // Consumer stalls about one cycle in four
  always @(posedge clk) begin
    if (rst_i || !bp_en) ex_ready_i <= 1'b1;
    else ex_ready_i <= ($random(seed) & 3) != 0;
  end

  //////////////////////////////////////////////////
  // Reference decode
  //////////////////////////////////////////////////
  function automatic alu_op_e arith_alu_op(input logic [2:0] f3, input logic sra);
    case (f3)
      3'd0:    return ALU_ADD;
      3'd1:    return ALU_SLL;
      3'd2:    return ALU_SLT;
      3'd3:    return ALU_SLTU;
      3'd4:    return ALU_XOR;
      3'd5:    return sra ? ALU_SRA : ALU_SRL;
      3'd6:    return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  function automatic id_ex_pipe_t ref_decode(input logic [31:0] w, input logic m_en,
                                             input logic kill);
    decoder_ctrl_t c;
    id_ex_pipe_t   p;
    logic [2:0]    f3;
    logic [6:0]    f7;
    logic          bad;
    f3  = w[14:12];
    f7  = w[31:25];
    c   = '0;
    bad = 1'b0;
    case (w[6:0])
      OPC_LUI, OPC_AUIPC: begin
        c.alu_en   = 1'b1;
        c.op_a_pc  = (w[6:0] == OPC_AUIPC);
        c.op_b_imm = 1'b1;
        c.rf_we    = 1'b1;
        c.imm_sel  = IMM_U;
      end
      OPC_JAL, OPC_JALR: begin                       // Link address from PC
        c.alu_en  = 1'b1;
        c.jmp     = 1'b1;
        c.op_a_pc = 1'b1;
        c.rf_we   = 1'b1;
        c.imm_sel = (w[6:0] == OPC_JAL) ? IMM_J : IMM_I;
        c.rf_re   = (w[6:0] == OPC_JAL) ? 2'b00 : 2'b01;
        bad       = (w[6:0] == OPC_JALR) && (f3 != 3'd0);
      end
      OPC_BRANCH: begin
        c.alu_en  = 1'b1;
        c.bch     = 1'b1;
        c.rf_re   = 2'b11;
        c.imm_sel = IMM_B;
        case (f3)
          3'd0:    c.alu_op = ALU_EQ;
          3'd1:    c.alu_op = ALU_NE;
          3'd4:    c.alu_op = ALU_LT;
          3'd5:    c.alu_op = ALU_GE;
          3'd6:    c.alu_op = ALU_LTU;
          3'd7:    c.alu_op = ALU_GEU;
          default: bad = 1'b1;
        endcase
      end
      OPC_LOAD, OPC_STORE: begin
        c.lsu_en   = 1'b1;
        c.lsu_size = f3[1:0];
        if (w[6:0] == OPC_LOAD) begin
          c.lsu_sext = !f3[2];                       // LBU, LHU zero extend
          c.rf_we    = 1'b1;
          c.rf_re    = 2'b01;
          c.imm_sel  = IMM_I;
          bad        = (f3 == 3'd3) || (f3 >= 3'd6);
        end else begin
          c.lsu_we  = 1'b1;
          c.rf_re   = 2'b11;
          c.imm_sel = IMM_S;
          bad       = (f3 > 3'd2);
        end
      end
      OPC_OP_IMM: begin
        c.alu_en   = 1'b1;
        c.alu_op   = arith_alu_op(f3, f7 == 7'h20);
        c.op_b_imm = 1'b1;
        c.rf_we    = 1'b1;
        c.rf_re    = 2'b01;
        c.imm_sel  = IMM_I;
        bad = (f3 == 3'd1 && f7 != 7'h00) || (f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20);
      end
      OPC_OP: begin
        c.rf_we = 1'b1;
        c.rf_re = 2'b11;
        if (f7 == FUNCT7_MULDIV) begin               // M extension
          bad      = !m_en;
          c.mul_en = !f3[2];
          c.div_en = f3[2];
          c.mul_op = f3[2] ? MUL_MUL : mul_op_e'(f3[1:0]);
          c.div_op = f3[2] ? div_op_e'(f3[1:0]) : DIV_DIV;
        end else begin
          c.alu_en = 1'b1;
          c.alu_op = (f7 == 7'h20 && f3 == 3'd0) ? ALU_SUB : arith_alu_op(f3, f7 == 7'h20);
          bad = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
        end
      end
      OPC_FENCE: begin
        c.fencei = (f3 == 3'd1);
        c.sys_en = (f3 == 3'd1);
        bad      = (f3 > 3'd1);
      end
      OPC_SYSTEM: begin
        c.sys_en = 1'b1;
        c.ecall  = (w[31:20] == 12'h000);
        c.ebreak = (w[31:20] == 12'h001);
        c.mret   = (w[31:20] == 12'h302);
        c.wfi    = (w[31:20] == 12'h105);
        bad = (w[19:7] != 13'd0) || !(c.ecall || c.ebreak || c.mret || c.wfi);
      end
      default: bad = 1'b1;
    endcase
    if (bad) begin
      c         = '0;
      c.illegal = 1'b1;
    end
    if (kill) begin                                  // Op fields survive a kill
      c.alu_en  = 1'b0;
      c.mul_en  = 1'b0;
      c.div_en  = 1'b0;
      c.lsu_en  = 1'b0;
      c.sys_en  = 1'b0;
      c.rf_we   = 1'b0;
      c.illegal = 1'b0;
    end
    case (c.imm_sel)
      IMM_I:   p.imm = {{20{w[31]}}, w[31:20]};
      IMM_S:   p.imm = {{20{w[31]}}, w[31:25], w[11:7]};
      IMM_B:   p.imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
      IMM_U:   p.imm = {w[31:12], 12'b0};
      IMM_J:   p.imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      default: p.imm = '0;
    endcase
    p.ctrl  = c;
    p.rs1   = w[19:15];
    p.rs2   = w[24:20];
    p.rd    = w[11:7];
    p.instr = w;
    return p;
  endfunction

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////
  task automatic check_value(input string name, input logic [127:0] got,
                             input logic [127:0] want);
    assert (got === want) else begin
      mismatches++;
      $display("MISMATCH at %0t ns: %s got %h expected %h", $time, name, got, want);
    end
  endtask

  always @(posedge clk) begin : scoreboard
    id_ex_pipe_t want;
    if (rst_i) begin
      hold_q = 1'b0;
    end else begin
      if (ex_valid_o && ex_ready_i) begin            // Output beat leaves
        beats++;
        if (sb.size() == 0) begin
          failures++;
          $display("Output beat at %0t ns without an accepted instruction", $time);
        end else begin
          want = sb.pop_front();
          check_value("ex_pipe_o.ctrl", ex_pipe_o.ctrl, want.ctrl);
          check_value("ex_pipe_o.rs1", ex_pipe_o.rs1, want.rs1);
          check_value("ex_pipe_o.rs2", ex_pipe_o.rs2, want.rs2);
          check_value("ex_pipe_o.rd", ex_pipe_o.rd, want.rd);
          check_value("ex_pipe_o.imm", ex_pipe_o.imm, want.imm);
          check_value("ex_pipe_o.instr", ex_pipe_o.instr, want.instr);
        end
      end
      if (hold_q) begin                              // Stalled beat must not move
        check_value("ex_valid_o", ex_valid_o, 1'b1);
        check_value("ex_pipe_o", ex_pipe_o, pipe_prev);
      end
      if (ex_valid_o && !ex_ready_i) check_value("instr_ready_o", instr_ready_o, 1'b0);
      if (instr_valid_i && instr_ready_o) begin      // Input accepted
        accepted++;
        want = ref_decode(instr_i, m_en_exp, kill_i);
        sb.push_back(want);
        if (want.ctrl.illegal) begin
          ill_cnt_exp++;
          last_ill_exp = instr_i;
        end
      end
      hold_q    = ex_valid_o && !ex_ready_i;
      pipe_prev = ex_pipe_o;
    end
  end

  //////////////////////////////////////////////////
  // Drivers
  //////////////////////////////////////////////////
  task automatic send_instr(input logic [31:0] word, input logic kill);
    int waited;
    instr_valid_i <= 1'b1;
    instr_i       <= word;
    kill_i        <= kill;
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
    end while (!instr_ready_o && waited < TIMEOUT);
    if (!instr_ready_o) begin
      failures++;
      $display("Timeout at %0t ns: instruction %h was never accepted", $time, word);
    end
    instr_valid_i <= 1'b0;
    kill_i        <= 1'b0;
  endtask

  // Waits until every accepted word has left the stage
  task automatic wait_drain();
    int waited;
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
    end while ((sb.size() != 0 || ex_valid_o) && waited < TIMEOUT);
    if (sb.size() != 0 || ex_valid_o) begin
      failures++;
      $display("Timeout at %0t ns: %0d beats still missing at the output", $time, sb.size());
    end
  endtask

  task automatic wb_access(input logic we, input logic [1:0] adr, input logic [31:0] wdat,
                           output logic [31:0] rdat);
    int waited;
    wb_req_i.cyc <= 1'b1;
    wb_req_i.stb <= 1'b1;
    wb_req_i.we  <= we;
    wb_req_i.adr <= adr;
    wb_req_i.dat <= wdat;
    wb_req_i.sel <= 4'hf;
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
    end while (!wb_rsp_o.ack && waited < TIMEOUT);
    if (!wb_rsp_o.ack) begin
      failures++;
      $display("Timeout at %0t ns: no Wishbone ack for address %0d", $time, adr);
    end
    rdat = wb_rsp_o.dat;
    wb_req_i <= '0;
    @(posedge clk);
    if (wb_rsp_o.ack) begin                          // Ack is a single pulse
      failures++;
      $display("Wishbone ack held longer than one cycle at %0t ns", $time);
    end
  endtask

  task automatic check_reg(input logic [1:0] adr, input logic [31:0] want, input string name);
    logic [31:0] rdat;
    wb_access(1'b0, adr, 32'd0, rdat);
    check_value(name, rdat, want);
  endtask

  task automatic wb_write(input logic [1:0] adr, input logic [31:0] wdat);
    logic [31:0] unused;
    wb_access(1'b1, adr, wdat, unused);
  endtask

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////
  initial begin : stimulus
    logic [31:0] w;
    int          k;
    int          cnt_before;
    clk           = 1'b0;
    rst_i         = 1'b1;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    kill_i        = 1'b0;
    ex_ready_i    = 1'b1;
    wb_req_i      = '0;
    for (int n = 0; n < N_RAND; n++) begin           // Half get a real opcode
      w = $random(seed);
      k = w[30:27] % 11;
      if (w[31]) w[6:0] = OPCODES[k*7 +: 7];
      rand_words[n] = w;
      rand_kill[n]  = ($random(seed) & 7) == 0;
    end
    repeat (10) @(posedge clk);
    rst_i <= 1'b0;

    repeat (3) begin                                 // Quiet after reset
      @(posedge clk);
      check_value("ex_valid_o", ex_valid_o, 1'b0);
      check_value("wb_rsp_o.ack", wb_rsp_o.ack, 1'b0);
    end
    check_reg(REG_CTRL, {31'b0, CTRL_RESET}, "REG_CTRL");
    check_reg(REG_ILL_CNT, 32'd0, "REG_ILL_CNT");
    check_reg(REG_ILL_INSN, 32'd0, "REG_ILL_INSN");

    foreach (base_words[n]) send_instr(base_words[n], 1'b0);
    wait_drain();

    // MUL..REMU with M on, then off
    for (int f3 = 0; f3 < 8; f3++) send_instr(32'h02b50533 | (f3 << 12), 1'b0);
    wait_drain();
    wb_write(REG_CTRL, 32'd0);
    m_en_exp = 1'b0;
    check_reg(REG_CTRL, 32'd0, "REG_CTRL");
    for (int f3 = 0; f3 < 8; f3++) send_instr(32'h02b50533 | (f3 << 12), 1'b0);
    wait_drain();
    wb_write(REG_CTRL, 32'd1);
    m_en_exp = 1'b1;

    check_reg(REG_ILL_CNT, ill_cnt_exp, "REG_ILL_CNT");
    check_reg(REG_ILL_INSN, last_ill_exp, "REG_ILL_INSN");
    wb_write(REG_ILL_CNT, 32'hffff_ffff);             // Any value clears
    ill_cnt_exp = 0;
    check_reg(REG_ILL_CNT, 32'd0, "REG_ILL_CNT");

    // Killed words, illegal ones among them
    cnt_before = ill_cnt_exp;
    foreach (base_words[n]) send_instr(base_words[n], 1'b1);
    wait_drain();
    check_reg(REG_ILL_CNT, cnt_before, "REG_ILL_CNT");

    bp_en <= 1'b1;
    for (int n = 0; n < N_RAND; n++) send_instr(rand_words[n], rand_kill[n]);
    wait_drain();
    bp_en <= 1'b0;
    check_reg(REG_ILL_CNT, ill_cnt_exp, "REG_ILL_CNT");
    check_reg(REG_ILL_INSN, last_ill_exp, "REG_ILL_INSN");

    if (accepted != beats || sb.size() != 0) begin
      failures++;
      $display("Accepted %0d words but saw %0d output beats", accepted, beats);
    end
    $display("Checked %0d beats: %0d mismatches, %0d other errors", beats, mismatches,
             failures);
    if (mismatches == 0 && failures == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

/* all.f */
src/rvd_pkg.sv
src/rvd_i_decoder.sv
src/rvd_m_decoder.sv
src/rvd_decoder.sv
src/rvd_cfg_regs.sv
src/rvd_id_stage.sv
bench/tb_rvd.sv

/* Bender.yml */
package:
  name: rvd

sources:
  - src/rvd_pkg.sv
  - src/rvd_i_decoder.sv
  - src/rvd_m_decoder.sv
  - src/rvd_decoder.sv
  - src/rvd_cfg_regs.sv
  - src/rvd_id_stage.sv
  - target: test
    files:
      - bench/tb_rvd.sv
